// ==== common/decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN   = 32;  // data and immediate width
    localparam int INST_W = 32;
    localparam int REG_W  = 5;

    typedef enum logic [6:0] {
        opc_load   = 7'h03,
        opc_op_imm = 7'h13,
        opc_auipc  = 7'h17,
        opc_store  = 7'h23,
        opc_op     = 7'h33,
        opc_lui    = 7'h37,
        opc_branch = 7'h63,
        opc_jalr   = 7'h67,
        opc_jal    = 7'h6f
    } opcode_e;

    typedef enum logic [2:0] {
        unit_alu,
        unit_bru,
        unit_lsu,
        unit_mul,
        unit_div
    } op_unit_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_lui, alu_auipc
    } alu_op_e;

    typedef enum logic [3:0] {
        bru_jal, bru_jalr, bru_beq, bru_bne, bru_blt, bru_bge, bru_bltu, bru_bgeu
    } bru_op_e;

    typedef enum logic [3:0] {
        lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
    } lsu_op_e;

    typedef enum logic [3:0] {
        mul_mul, mul_mulh, mul_mulhsu, mul_mulhu
    } mul_op_e;

    typedef enum logic [3:0] {
        div_div, div_divu, div_rem, div_remu
    } div_op_e;

    // field meaning depends on the unit
    typedef union packed {
        alu_op_e alu_op;
        bru_op_e bru_op;
        lsu_op_e lsu_op;
        mul_op_e mul_op;
        div_op_e div_op;
    } sub_op_u;

    typedef enum logic [1:0] {
        arg_none,
        arg_reg,
        arg_imm
    } arg_src_e;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        opcode_e          opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]      imm;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        opcode_e          opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]       imm_hi;  // imm[11:5]
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [4:0]       imm_lo;  // imm[4:0]
        opcode_e          opcode;
    } s_fmt_t;

    typedef struct packed {
        logic             imm_12;
        logic [5:0]       imm_10_5;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [3:0]       imm_4_1;
        logic             imm_11;
        opcode_e          opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [INST_W-1:12] imm_hi;  // upper 20 bits
        logic [REG_W-1:0]   rd;
        opcode_e            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic             imm_20;
        logic [9:0]       imm_10_1;
        logic             imm_11;
        logic [7:0]       imm_19_12;
        logic [REG_W-1:0] rd;
        opcode_e          opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fetch_pack_t;

    typedef struct packed {
        logic             legal;
        logic [XLEN-1:0]  pc;
        op_unit_e         unit;
        sub_op_u          sub_op;
        arg_src_e         arg1_src;
        arg_src_e         arg2_src;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  imm;      // sign-extended
        logic [REG_W-1:0] rd;
        logic             rd_enable;
        logic             rs1_need_map;
        logic             rs2_need_map;
        logic             need_rename;
    } uop_t;

endpackage

// ==== decode/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
    input  decode_pkg::fetch_pack_t fetch_pack_i,
    output decode_pkg::uop_t        uop_o
);
    import decode_pkg::*;

    inst_u           inst;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // register-register and register-immediate share this mapping
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3);
        alu_op_e op;
        case (funct3)
            3'h0:    op = alu_add;
            3'h1:    op = alu_sll;
            3'h2:    op = alu_slt;
            3'h3:    op = alu_sltu;
            3'h4:    op = alu_xor;
            3'h5:    op = alu_srl;
            3'h6:    op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign inst  = fetch_pack_i.inst;
    assign imm_i = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{(XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_hi, 12'b0};
    assign imm_j = {{(XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    always_comb begin
        uop_o          = '0;
        uop_o.legal    = 1'b1;
        uop_o.pc       = fetch_pack_i.pc;
        uop_o.unit     = unit_alu;
        uop_o.arg1_src = arg_none;
        uop_o.arg2_src = arg_none;

        case (inst.r.opcode)
            opc_lui: begin
                uop_o.sub_op.alu_op = alu_lui;
                uop_o.imm           = imm_u;
                uop_o.rd            = inst.u.rd;
                uop_o.rd_enable     = 1'b1;
            end
            opc_auipc: begin
                uop_o.sub_op.alu_op = alu_auipc;  // pc supplied by the alu
                uop_o.imm           = imm_u;
                uop_o.rd            = inst.u.rd;
                uop_o.rd_enable     = 1'b1;
            end
            opc_jal: begin
                uop_o.unit          = unit_bru;
                uop_o.sub_op.bru_op = bru_jal;
                uop_o.imm           = imm_j;
                uop_o.rd            = inst.j.rd;
                uop_o.rd_enable     = 1'b1;
            end
            opc_jalr: begin
                uop_o.unit          = unit_bru;
                uop_o.sub_op.bru_op = bru_jalr;
                uop_o.arg1_src      = arg_reg;
                uop_o.rs1           = inst.i.rs1;
                uop_o.imm           = imm_i;
                uop_o.rd            = inst.i.rd;
                uop_o.rd_enable     = 1'b1;
                uop_o.legal         = (inst.i.funct3 == 3'h0);
            end
            opc_branch: begin
                uop_o.unit     = unit_bru;
                uop_o.arg1_src = arg_reg;
                uop_o.arg2_src = arg_reg;
                uop_o.rs1      = inst.b.rs1;
                uop_o.rs2      = inst.b.rs2;
                uop_o.imm      = imm_b;
                case (inst.b.funct3)
                    3'h0:    uop_o.sub_op.bru_op = bru_beq;
                    3'h1:    uop_o.sub_op.bru_op = bru_bne;
                    3'h4:    uop_o.sub_op.bru_op = bru_blt;
                    3'h5:    uop_o.sub_op.bru_op = bru_bge;
                    3'h6:    uop_o.sub_op.bru_op = bru_bltu;
                    3'h7:    uop_o.sub_op.bru_op = bru_bgeu;
                    default: uop_o.legal = 1'b0;
                endcase
            end
            opc_load: begin
                uop_o.unit      = unit_lsu;
                uop_o.arg1_src  = arg_reg;
                uop_o.rs1       = inst.i.rs1;
                uop_o.imm       = imm_i;
                uop_o.rd        = inst.i.rd;
                uop_o.rd_enable = 1'b1;
                case (inst.i.funct3)
                    3'h0:    uop_o.sub_op.lsu_op = lsu_lb;
                    3'h1:    uop_o.sub_op.lsu_op = lsu_lh;
                    3'h2:    uop_o.sub_op.lsu_op = lsu_lw;
                    3'h4:    uop_o.sub_op.lsu_op = lsu_lbu;
                    3'h5:    uop_o.sub_op.lsu_op = lsu_lhu;
                    default: uop_o.legal = 1'b0;
                endcase
            end
            opc_store: begin
                uop_o.unit     = unit_lsu;
                uop_o.arg1_src = arg_reg;  // base
                uop_o.arg2_src = arg_reg;  // store data
                uop_o.rs1      = inst.s.rs1;
                uop_o.rs2      = inst.s.rs2;
                uop_o.imm      = imm_s;
                case (inst.s.funct3)
                    3'h0:    uop_o.sub_op.lsu_op = lsu_sb;
                    3'h1:    uop_o.sub_op.lsu_op = lsu_sh;
                    3'h2:    uop_o.sub_op.lsu_op = lsu_sw;
                    default: uop_o.legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                uop_o.arg1_src  = arg_reg;
                uop_o.arg2_src  = arg_imm;
                uop_o.rs1       = inst.i.rs1;
                uop_o.imm       = imm_i;
                uop_o.rd        = inst.i.rd;
                uop_o.rd_enable = 1'b1;
                case (inst.i.funct3)
                    3'h1: begin
                        uop_o.sub_op.alu_op = alu_sll;
                        uop_o.legal         = (inst.r.funct7 == 7'h00);
                    end
                    3'h5: begin
                        if (inst.r.funct7 == 7'h00) begin
                            uop_o.sub_op.alu_op = alu_srl;
                        end else if (inst.r.funct7 == 7'h20) begin
                            uop_o.sub_op.alu_op = alu_sra;
                        end else begin
                            uop_o.legal = 1'b0;
                        end
                    end
                    default: uop_o.sub_op.alu_op = alu_from_funct3(inst.i.funct3);
                endcase
            end
            opc_op: begin
                uop_o.arg1_src  = arg_reg;
                uop_o.arg2_src  = arg_reg;
                uop_o.rs1       = inst.r.rs1;
                uop_o.rs2       = inst.r.rs2;
                uop_o.rd        = inst.r.rd;
                uop_o.rd_enable = 1'b1;
                case (inst.r.funct7)
                    7'h00: uop_o.sub_op.alu_op = alu_from_funct3(inst.r.funct3);
                    7'h20: begin
                        case (inst.r.funct3)
                            3'h0:    uop_o.sub_op.alu_op = alu_sub;
                            3'h5:    uop_o.sub_op.alu_op = alu_sra;
                            default: uop_o.legal = 1'b0;
                        endcase
                    end
                    7'h01: begin  // M extension
                        if (!inst.r.funct3[2]) begin
                            uop_o.unit = unit_mul;
                            case (inst.r.funct3[1:0])
                                2'h0:    uop_o.sub_op.mul_op = mul_mul;
                                2'h1:    uop_o.sub_op.mul_op = mul_mulh;
                                2'h2:    uop_o.sub_op.mul_op = mul_mulhsu;
                                default: uop_o.sub_op.mul_op = mul_mulhu;
                            endcase
                        end else begin
                            uop_o.unit = unit_div;
                            case (inst.r.funct3[1:0])
                                2'h0:    uop_o.sub_op.div_op = div_div;
                                2'h1:    uop_o.sub_op.div_op = div_divu;
                                2'h2:    uop_o.sub_op.div_op = div_rem;
                                default: uop_o.sub_op.div_op = div_remu;
                            endcase
                        end
                    end
                    default: uop_o.legal = 1'b0;
                endcase
            end
            default: uop_o.legal = 1'b0;  // fence, system and the rest
        endcase

        // x0 needs no mapping and no new physical register
        uop_o.rs1_need_map = (uop_o.arg1_src == arg_reg) && (uop_o.rs1 != '0);
        uop_o.rs2_need_map = (uop_o.arg2_src == arg_reg) && (uop_o.rs2 != '0);
        uop_o.need_rename  = uop_o.rd_enable && (uop_o.rd != '0);
    end

endmodule

// ==== decode/decode_issue_stage.sv ====
`timescale 1ns/10ps

module decode_issue_stage #(
    parameter int LANES = 2
) (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  decode_pkg::uop_t     uop_i [LANES],
    input  logic [LANES-1:0]     fetch_valid_i,
    input  logic [LANES-1:0]     rename_ready_i,
    input  logic                 flush_i,

    output logic [LANES-1:0]     pop_valid_o,
    output decode_pkg::uop_t     uop_o [LANES],
    output logic [LANES-1:0]     uop_valid_o,
    output logic                 stall_o
);

    logic [LANES-1:0] accept;
    logic [LANES-1:0] refused;

    // lanes move independently and a flush blocks all of them
    assign accept  = fetch_valid_i & rename_ready_i & {LANES{~flush_i}};
    assign refused = fetch_valid_i & ~accept;

    assign pop_valid_o = accept;  // fetch drops these entries
    assign stall_o     = !flush_i && (|refused);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            uop_valid_o <= '0;
        end else begin
            uop_valid_o <= accept;  // fresh each cycle and zero after flush
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (accept[l]) begin
                uop_o[l] <= uop_i[l];
            end
        end
    end

endmodule

// ==== verilog/decode_top.sv ====
`timescale 1ns/10ps

module decode_top #(
    parameter int LANES = 2
) (
    input  logic                      clk,
    input  logic                      arst_n_i,

    input  decode_pkg::fetch_pack_t   fetch_pack_i [LANES],
    input  logic [LANES-1:0]          fetch_valid_i,
    input  logic [LANES-1:0]          rename_ready_i,
    input  logic                      flush_i,

    output logic [LANES-1:0]          pop_valid_o,
    output decode_pkg::uop_t          uop_o [LANES],
    output logic [LANES-1:0]          uop_valid_o,
    output logic                      stall_o
);
    import decode_pkg::*;

    uop_t dec_uop [LANES];  // combinational decode per lane

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        inst_decoder u_inst_decoder (
            .fetch_pack_i (fetch_pack_i[l]),
            .uop_o        (dec_uop[l])
        );
    end

    decode_issue_stage #(
        .LANES (LANES)
    ) u_decode_issue_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .uop_i          (dec_uop),
        .fetch_valid_i  (fetch_valid_i),
        .rename_ready_i (rename_ready_i),
        .flush_i        (flush_i),
        .pop_valid_o    (pop_valid_o),
        .uop_o          (uop_o),
        .uop_valid_o    (uop_valid_o),
        .stall_o        (stall_o)
    );

endmodule

// ==== verification/decode_properties.sv ====
`timescale 1ns/10ps

module decode_properties #(
    parameter int LANES = 2
) (
    input logic             clk,
    input logic             arst_n_i,
    input logic [LANES-1:0] fetch_valid_i,
    input logic [LANES-1:0] rename_ready_i,
    input logic             flush_i,
    input logic [LANES-1:0] pop_valid_i,
    input logic [LANES-1:0] uop_valid_i,
    input logic             stall_i
);

    int fail_count = 0;  // read by the testbench at the end of the run

    a_pop_in_mask: assert property (@(posedge clk) disable iff (!arst_n_i)
        (pop_valid_i & ~(fetch_valid_i & rename_ready_i)) == '0)
        else begin
            fail_count = fail_count + 1;
            $error("pop_valid set on a lane that is not valid and ready");
        end

    a_flush_no_pop: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |-> (pop_valid_i == '0))
        else begin
            fail_count = fail_count + 1;
            $error("lane popped during flush");
        end

    a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> (uop_valid_i == '0))
        else begin
            fail_count = fail_count + 1;
            $error("uop_valid set in the cycle after flush");
        end

    a_no_stall_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |-> !stall_i)
        else begin
            fail_count = fail_count + 1;
            $error("stall raised during flush");
        end

endmodule

bind decode_top decode_properties #(
    .LANES (LANES)
) u_decode_properties (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .fetch_valid_i  (fetch_valid_i),
    .rename_ready_i (rename_ready_i),
    .flush_i        (flush_i),
    .pop_valid_i    (pop_valid_o),
    .uop_valid_i    (uop_valid_o),
    .stall_i        (stall_o)
);

// ==== verification/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// base integer op selected by funct3
function automatic alu_op_e base_alu_op(input logic [2:0] f3);
    case (f3)
        3'h0:    return alu_add;
        3'h1:    return alu_sll;
        3'h2:    return alu_slt;
        3'h3:    return alu_sltu;
        3'h4:    return alu_xor;
        3'h5:    return alu_srl;
        3'h6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

// expected micro-op straight from the instruction encoding
function automatic uop_t expect_uop(input logic [31:0] pc, input logic [31:0] w);
    uop_t       u;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       has_rs1;
    logic       has_rs2;
    logic       has_rd;
    f3      = w[14:12];
    f7      = w[31:25];
    has_rs1 = 1'b0;
    has_rs2 = 1'b0;
    has_rd  = 1'b0;
    u       = '0;
    u.legal = 1'b1;
    u.pc    = pc;
    u.unit  = unit_alu;
    case (w[6:0])
        7'h37, 7'h17: begin  // lui, auipc
            u.sub_op.alu_op = (w[5]) ? alu_lui : alu_auipc;
            u.imm           = {w[31:12], 12'h000};
            has_rd          = 1'b1;
        end
        7'h6f: begin
            u.unit          = unit_bru;
            u.sub_op.bru_op = bru_jal;
            u.imm           = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            has_rd          = 1'b1;
        end
        7'h67: begin
            u.unit          = unit_bru;
            u.sub_op.bru_op = bru_jalr;
            u.imm           = {{20{w[31]}}, w[31:20]};
            u.legal         = (f3 == 3'h0);
            has_rs1         = 1'b1;
            has_rd          = 1'b1;
        end
        7'h63: begin
            u.unit  = unit_bru;
            u.imm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            has_rs1 = 1'b1;
            has_rs2 = 1'b1;
            case (f3)
                3'h0:    u.sub_op.bru_op = bru_beq;
                3'h1:    u.sub_op.bru_op = bru_bne;
                3'h4:    u.sub_op.bru_op = bru_blt;
                3'h5:    u.sub_op.bru_op = bru_bge;
                3'h6:    u.sub_op.bru_op = bru_bltu;
                3'h7:    u.sub_op.bru_op = bru_bgeu;
                default: u.legal = 1'b0;
            endcase
        end
        7'h03: begin
            u.unit  = unit_lsu;
            u.imm   = {{20{w[31]}}, w[31:20]};
            has_rs1 = 1'b1;
            has_rd  = 1'b1;
            case (f3)
                3'h0:    u.sub_op.lsu_op = lsu_lb;
                3'h1:    u.sub_op.lsu_op = lsu_lh;
                3'h2:    u.sub_op.lsu_op = lsu_lw;
                3'h4:    u.sub_op.lsu_op = lsu_lbu;
                3'h5:    u.sub_op.lsu_op = lsu_lhu;
                default: u.legal = 1'b0;
            endcase
        end
        7'h23: begin
            u.unit  = unit_lsu;
            u.imm   = {{20{w[31]}}, w[31:25], w[11:7]};
            has_rs1 = 1'b1;
            has_rs2 = 1'b1;
            case (f3)
                3'h0:    u.sub_op.lsu_op = lsu_sb;
                3'h1:    u.sub_op.lsu_op = lsu_sh;
                3'h2:    u.sub_op.lsu_op = lsu_sw;
                default: u.legal = 1'b0;
            endcase
        end
        7'h13: begin
            u.imm           = {{20{w[31]}}, w[31:20]};
            u.sub_op.alu_op = base_alu_op(f3);
            has_rs1         = 1'b1;
            has_rd          = 1'b1;
            if (f3 == 3'h1) begin
                u.legal = (f7 == 7'h00);
            end else if (f3 == 3'h5) begin
                u.legal = (f7 == 7'h00) || (f7 == 7'h20);
                if (f7 == 7'h20) begin
                    u.sub_op.alu_op = alu_sra;
                end
            end
        end
        7'h33: begin
            has_rs1 = 1'b1;
            has_rs2 = 1'b1;
            has_rd  = 1'b1;
            if (f7 == 7'h00) begin
                u.sub_op.alu_op = base_alu_op(f3);
            end else if (f7 == 7'h20) begin
                u.sub_op.alu_op = (f3 == 3'h0) ? alu_sub : alu_sra;
                u.legal         = (f3 == 3'h0) || (f3 == 3'h5);
            end else if (f7 == 7'h01) begin  // funct3[2] splits mul from div
                u.unit = f3[2] ? unit_div : unit_mul;
                if (f3[2]) begin
                    u.sub_op.div_op = div_op_e'({2'b00, f3[1:0]});
                end else begin
                    u.sub_op.mul_op = mul_op_e'({2'b00, f3[1:0]});
                end
            end else begin
                u.legal = 1'b0;
            end
        end
        default: u.legal = 1'b0;
    endcase
    if (has_rs1) begin
        u.arg1_src = arg_reg;
        u.rs1      = w[19:15];
    end
    if (has_rs2) begin
        u.arg2_src = arg_reg;
        u.rs2      = w[24:20];
    end
    if (w[6:0] == 7'h13) begin
        u.arg2_src = arg_imm;
    end
    if (has_rd) begin
        u.rd        = w[11:7];
        u.rd_enable = 1'b1;
    end
    u.rs1_need_map = has_rs1 && (w[19:15] != 5'd0);
    u.rs2_need_map = has_rs2 && (w[24:20] != 5'd0);
    u.need_rename  = has_rd && (w[11:7] != 5'd0);
    return u;
endfunction

`endif

// ==== verification/decode_monitor.sv ====
`timescale 1ns/10ps

module decode_monitor #(
    parameter int LANES = 2
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  decode_pkg::fetch_pack_t fetch_pack_i [LANES],
    input  logic [LANES-1:0]        fetch_valid_i,
    input  logic [LANES-1:0]        rename_ready_i,
    input  logic                    flush_i,
    input  logic [LANES-1:0]        pop_valid_i,
    input  decode_pkg::uop_t        uop_i [LANES],
    input  logic [LANES-1:0]        uop_valid_i,
    input  logic                    stall_i,
    input  int                      test_idx_i,
    input  logic [63:0]             test_name_i,
    output int                      checks_o,
    output int                      errors_o
);
    import decode_pkg::*;

    `include "decode_model.svh"

    uop_t             exp_uop [LANES];  // predicted at the previous edge
    logic [LANES-1:0] exp_valid = '0;
    int               cur_idx = 0;
    logic [63:0]      cur_name = "rv32base";
    int               test_checks = 0;
    int               test_errors = 0;
    int               total_checks = 0;
    int               total_errors = 0;

    assign checks_o = total_checks;
    assign errors_o = total_errors;

    task automatic compare(input string what, input int lane,
                           input logic [127:0] expected, input logic [127:0] actual);
        test_checks++;
        total_checks++;
        if (expected !== actual) begin
            test_errors++;
            total_errors++;
            $display("Mismatch in %s: %s lane %0d expected %h actual %h",
                     test_name_i, what, lane, expected, actual);
        end
    endtask

    // registered outputs still hold last edge's values here
    always @(posedge clk) begin
        logic [LANES-1:0] accept;
        logic             exp_stall;
        if (!arst_n_i) begin
            exp_valid = '0;
        end else begin
            accept    = fetch_valid_i & rename_ready_i & {LANES{!flush_i}};
            exp_stall = !flush_i && ((fetch_valid_i & ~accept) != '0);
            compare("uop_valid", 0, 128'(exp_valid), 128'(uop_valid_i));
            for (int l = 0; l < LANES; l++) begin
                if (exp_valid[l] && uop_valid_i[l]) begin
                    if (exp_uop[l].legal) begin
                        compare("uop", l, 128'(exp_uop[l]), 128'(uop_i[l]));
                    end else begin
                        compare("legal", l, 128'(1'b0), 128'(uop_i[l].legal));
                    end
                end
            end
            compare("pop_valid", 0, 128'(accept), 128'(pop_valid_i));
            compare("stall", 0, 128'(exp_stall), 128'(stall_i));

            for (int l = 0; l < LANES; l++) begin
                exp_uop[l] = expect_uop(fetch_pack_i[l].pc, fetch_pack_i[l].inst);
            end
            exp_valid = accept;

            if (test_idx_i != cur_idx) begin
                $display("test %0d %s finished: %0d checks, %0d errors",
                         cur_idx, cur_name, test_checks, test_errors);
                cur_idx     = test_idx_i;
                cur_name    = test_name_i;
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// ==== verification/decode_tb.sv ====
`timescale 1ns/10ps

module decode_tb;
    import decode_pkg::*;

    localparam int LANES          = 2;
    localparam int TEST_CYCLES    = 200;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 50;

    logic             clk;
    logic             arst_n;
    fetch_pack_t      fetch_pack [LANES];
    logic [LANES-1:0] fetch_valid;
    logic [LANES-1:0] rename_ready;
    logic             flush;
    logic [LANES-1:0] pop_valid;
    uop_t             uop [LANES];
    logic [LANES-1:0] uop_valid;
    logic             stall;
    int               test_idx;
    logic [63:0]      test_name;
    int               checks;
    int               errors;
    int               cycles = 0;

    decode_top #(
        .LANES (LANES)
    ) dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .fetch_pack_i   (fetch_pack),
        .fetch_valid_i  (fetch_valid),
        .rename_ready_i (rename_ready),
        .flush_i        (flush),
        .pop_valid_o    (pop_valid),
        .uop_o          (uop),
        .uop_valid_o    (uop_valid),
        .stall_o        (stall)
    );

    decode_monitor #(
        .LANES (LANES)
    ) u_decode_monitor (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .fetch_pack_i   (fetch_pack),
        .fetch_valid_i  (fetch_valid),
        .rename_ready_i (rename_ready),
        .flush_i        (flush),
        .pop_valid_i    (pop_valid),
        .uop_i          (uop),
        .uop_valid_i    (uop_valid),
        .stall_i        (stall),
        .test_idx_i     (test_idx),
        .test_name_i    (test_name),
        .checks_o       (checks),
        .errors_o       (errors)
    );

    function automatic logic [31:0] pc_word();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    // one of the nine kept opcodes with a legal funct3/funct7
    function automatic logic [31:0] legal_base_word();
        logic [31:0] w;
        logic [3:0]  kind;
        logic [2:0]  f3;
        w    = $urandom;
        kind = 4'($urandom % 9);
        f3   = w[14:12];
        case (kind)
            4'd0: w[6:0] = 7'h37;
            4'd1: w[6:0] = 7'h17;
            4'd2: w[6:0] = 7'h6f;
            4'd3: begin
                w[6:0]   = 7'h67;
                w[14:12] = 3'h0;
            end
            4'd4: begin
                w[6:0] = 7'h63;
                if (f3[2:1] == 2'b01) begin
                    w[14] = 1'b1;
                end
            end
            4'd5: begin
                w[6:0] = 7'h03;
                if (f3 == 3'h3 || f3[2:1] == 2'b11) begin
                    w[14:12] = 3'h2;
                end
            end
            4'd6: begin
                w[6:0]   = 7'h23;
                w[14:12] = f3 % 3'd3;
            end
            4'd7: begin
                w[6:0] = 7'h13;
                if (f3 == 3'h1) begin
                    w[31:25] = 7'h00;
                end else if (f3 == 3'h5) begin
                    w[31:25] = {1'b0, w[30], 5'h00};
                end
            end
            default: begin
                w[6:0] = 7'h33;
                if (f3 == 3'h0 || f3 == 3'h5) begin
                    w[31:25] = {1'b0, w[30], 5'h00};
                end else begin
                    w[31:25] = 7'h00;
                end
            end
        endcase
        return w;
    endfunction

    function automatic logic [31:0] mext_word();
        logic [31:0] w;
        w        = $urandom;
        w[6:0]   = 7'h33;
        w[31:25] = 7'h01;
        return w;
    endfunction

    function automatic logic [31:0] illegal_word();
        logic [31:0] w;
        logic [2:0]  kind;
        w    = $urandom;
        kind = 3'($urandom % 6);
        case (kind)
            3'd1: w[6:0] = 7'h0f;  // fence
            3'd2: w[6:0] = 7'h73;  // system
            3'd3: begin
                w[6:0]   = 7'h63;
                w[14:13] = 2'b01;
            end
            3'd4: begin
                w[6:0] = 7'h33;
                w[31]  = 1'b1;  // funct7 out of range
            end
            3'd5: begin
                w[6:0]   = 7'h03;
                w[13:12] = 2'b11;
            end
            default: w[1:0] = 2'b10;  // compressed space
        endcase
        return w;
    endfunction

    task automatic drive_cycle(input int idx);
        for (int l = 0; l < LANES; l++) begin
            case (idx)
                1:       fetch_pack[l] = {pc_word(), mext_word()};
                2:       fetch_pack[l] = {pc_word(), illegal_word()};
                default: fetch_pack[l] = {pc_word(), legal_base_word()};
            endcase
        end
        if (idx < 3) begin
            fetch_valid  = '1;
            rename_ready = '1;
            flush        = 1'b0;
        end else begin
            fetch_valid  = LANES'($urandom);
            rename_ready = LANES'($urandom);
            flush        = (idx == 4) && (($urandom % 4) == 0);
        end
    endtask

    task automatic run_test(input int idx, input logic [63:0] name);
        repeat (TEST_CYCLES) begin
            @(negedge clk);
            test_idx  = idx;
            test_name = name;
            drive_cycle(idx);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h8c30));
        arst_n       = 1'b0;
        flush        = 1'b0;
        fetch_valid  = '0;
        rename_ready = '0;
        test_idx     = 0;
        test_name    = "rv32base";
        for (int l = 0; l < LANES; l++) begin
            fetch_pack[l] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_test(0, "rv32base");
        run_test(1, "mext_ops");
        run_test(2, "illegals");
        run_test(3, "backpres");
        run_test(4, "flushing");

        @(negedge clk);
        test_idx    = NUM_TESTS;
        test_name   = "finished";
        fetch_valid = '0;
        flush       = 1'b0;
        repeat (2) @(negedge clk);

        $display("closing: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, dut_i.u_decode_properties.fail_count);
        if (errors == 0 && dut_i.u_decode_properties.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verification
common/decode_pkg.sv
decode/inst_decoder.sv
decode/decode_issue_stage.sv
verilog/decode_top.sv
verification/decode_properties.sv
verification/decode_monitor.sv
verification/decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sources.f --top-module decode_tb -o decode_sim

./obj_dir/decode_sim +verilator+error+limit+100 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
